// File: Bender.yml
package:
  name: cvita_debug

sources:
  # Design, in compile order
  - verilog/cvita_debug_pkg.sv
  - verilog/cvita_pipe_reg.sv
  - verilog/cvita_packet_monitor.sv
  - verilog/cvita_length_check.sv
  - verilog/cvita_debug_top.sv

  # Testbench
  - target: simulation
    files:
      - sim/tb_cvita_debug_top.sv

// File: sim/tb_cvita_debug_top.sv
/*
 * Testbench for the CVITA debug tap: random packets with valid gaps and
 * ready stalls, checked against a packet and counter model
 */
`default_nettype none
`timescale 1ns/1ps

module tb_cvita_debug_top;

   localparam int COUNT_W        = 32;
   localparam int DW             = cvita_debug_pkg::DATA_W;
   localparam int LW             = cvita_debug_pkg::HDR_LEN_W;
   localparam int CLK_PERIOD     = 100;
   localparam int DRIVE_DELAY    = 1;
   localparam int TIMEOUT_CYCLES = 2000;

   logic               clk;
   logic               reset;
   logic               clear;
   logic [DW-1:0]      i_tdata;
   logic               i_tlast;
   logic               i_tvalid;
   logic               i_tready;
   logic [DW-1:0]      o_tdata;
   logic               o_tlast;
   logic               o_tvalid;
   logic               o_tready;
   logic               pkt_strobe;
   logic [DW-1:0]      header;
   logic [DW-1:0]      timestamp;
   logic [LW-1:0]      actual_length;
   logic [DW-1:0]      checksum;
   logic [COUNT_W-1:0] pkt_count;
   logic [COUNT_W-1:0] ctrl_pkt_count;
   logic               len_ok_strobe;
   logic               len_err_strobe;
   logic [COUNT_W-1:0] err_count;

   logic [31:0]        lcg_state = 32'd46777;

   // Expected beats ({last, data}) and per-packet results
   logic [DW:0]        beat_q[$];
   logic [DW-1:0]      hdr_q[$];
   logic [DW-1:0]      ts_q[$];
   logic [DW-1:0]      sum_q[$];
   logic [LW-1:0]      len_q[$];
   logic               err_q[$];

   logic [DW-1:0]      last_ts;
   logic [COUNT_W-1:0] model_pkts;
   logic [COUNT_W-1:0] model_ctrl;
   logic [COUNT_W-1:0] model_errs;
   logic               verdict_pending;
   logic               verdict_err;

   cvita_debug_top #(
      .COUNT_W (COUNT_W)
   ) dut_i (
      .clk            (clk),
      .reset          (reset),
      .clear          (clear),
      .i_tdata        (i_tdata),
      .i_tlast        (i_tlast),
      .i_tvalid       (i_tvalid),
      .i_tready       (i_tready),
      .o_tdata        (o_tdata),
      .o_tlast        (o_tlast),
      .o_tvalid       (o_tvalid),
      .o_tready       (o_tready),
      .pkt_strobe     (pkt_strobe),
      .header         (header),
      .timestamp      (timestamp),
      .actual_length  (actual_length),
      .checksum       (checksum),
      .pkt_count      (pkt_count),
      .ctrl_pkt_count (ctrl_pkt_count),
      .len_ok_strobe  (len_ok_strobe),
      .len_err_strobe (len_err_strobe),
      .err_count      (err_count)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Upper bits have the longest period
   function automatic int unsigned pick(input int unsigned n);
      return (lcg_next() >> 12) % n;
   endfunction

   function automatic logic [DW-1:0] rand_word();
      return {lcg_next(), lcg_next()};
   endfunction

   task automatic stop_with_failure();
      $display("sim failed");
      $fatal(1, "stopping at first failure");
   endtask

   task automatic check_equal(input logic [DW-1:0] actual, input logic [DW-1:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("[ERROR] %0t: %s is %h, expected %h", $time, what, actual, expected);
         stop_with_failure();
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timed out waiting for %s", what);
      stop_with_failure();
   endtask

   // One clock, then new output ready; accepted reflects the edge itself
   task automatic next_cycle(output logic accepted);
      @(posedge clk);
      accepted = i_tvalid && i_tready;
      #DRIVE_DELAY;
      o_tready = (pick(4) != 0);
   endtask

   task automatic send_beat(input logic [DW-1:0] data, input logic last);
      int   gap;
      int   waited;
      logic accepted;
      gap = (pick(4) == 0) ? pick(3) + 1 : 0;
      i_tvalid = 1'b0;
      repeat (gap) next_cycle(accepted);
      i_tvalid = 1'b1;
      i_tdata  = data;
      i_tlast  = last;
      beat_q.push_back({last, data});
      waited   = 0;
      accepted = 1'b0;
      while (!accepted) begin
         if (waited == TIMEOUT_CYCLES) report_timeout("the input side to accept a beat");
         next_cycle(accepted);
         waited++;
      end
      i_tvalid = 1'b0;
   endtask

   task automatic send_packet(input logic ctrl, input logic has_time, input int nwords,
                              input logic len_ok);
      logic [DW-1:0] words[8];
      logic [DW-1:0] hdr;
      logic [DW-1:0] sum;
      logic [LW-1:0] len_field;
      int            beats;
      beats = nwords + 1;
      // A correct field is anything that rounds up to the real length
      if (len_ok) len_field = LW'(beats * 8 - int'(pick(8)));
      else len_field = LW'(beats * 8 + 1 + int'(pick(64)));
      hdr = rand_word();
      hdr[cvita_debug_pkg::HDR_CTRL_BIT]     = ctrl;
      hdr[cvita_debug_pkg::HDR_HAS_TIME_BIT] = has_time;
      hdr[LW-1:0] = len_field;
      sum = '0;
      for (int i = 0; i < nwords; i++) begin
         words[i] = rand_word();
         if (has_time && i == 0) last_ts = words[i];
         else sum = sum ^ words[i];
      end
      hdr_q.push_back(hdr);
      ts_q.push_back(last_ts);
      len_q.push_back(LW'(beats * 8));
      sum_q.push_back(sum);
      err_q.push_back(!len_ok);
      send_beat(hdr, 1'b0);
      for (int i = 0; i < nwords; i++) begin
         send_beat(words[i], i == nwords - 1);
      end
   endtask

   task automatic wait_idle();
      int   waited;
      logic accepted;
      waited = 0;
      while (beat_q.size() != 0 || hdr_q.size() != 0 || verdict_pending) begin
         if (waited == TIMEOUT_CYCLES) report_timeout("the tap to drain all packets");
         next_cycle(accepted);
         waited++;
      end
   endtask

   task automatic clear_counters();
      logic accepted;
      clear = 1'b1;
      next_cycle(accepted);
      clear      = 1'b0;
      model_pkts = '0;
      model_ctrl = '0;
      model_errs = '0;
      check_equal(pkt_count, '0, "pkt_count after clear");
      check_equal(ctrl_pkt_count, '0, "ctrl_pkt_count after clear");
      check_equal(err_count, '0, "err_count after clear");
   endtask

   task automatic check_packet();
      logic [DW-1:0] hdr;
      if (hdr_q.size() == 0) begin
         $display("[ERROR] %0t: packet strobe with no packet outstanding", $time);
         stop_with_failure();
      end
      hdr = hdr_q.pop_front();
      check_equal(header, hdr, "header");
      check_equal(timestamp, ts_q.pop_front(), "timestamp");
      check_equal(actual_length, len_q.pop_front(), "actual_length");
      check_equal(checksum, sum_q.pop_front(), "checksum");
      verdict_err = err_q.pop_front();
      model_pkts++;
      if (hdr[cvita_debug_pkg::HDR_CTRL_BIT]) model_ctrl++;
      check_equal(pkt_count, model_pkts, "pkt_count");
      check_equal(ctrl_pkt_count, model_ctrl, "ctrl_pkt_count");
   endtask

   // Samples the values the DUT saw at each rising edge
   initial begin : watch_outputs
      logic [DW:0] beat;
      logic        strobe_due;
      strobe_due = 1'b0;
      forever begin
         @(posedge clk);
         if (!reset) begin
            // Strobe follows a transferred last beat by one cycle
            check_equal(pkt_strobe, strobe_due, "pkt_strobe");
            strobe_due = o_tvalid && o_tready && o_tlast;
            if (o_tvalid && o_tready) begin
               if (beat_q.size() == 0) begin
                  $display("[ERROR] %0t: output beat with no matching input beat", $time);
                  stop_with_failure();
               end
               beat = beat_q.pop_front();
               check_equal(o_tdata, beat[DW-1:0], "o_tdata");
               check_equal(o_tlast, beat[DW], "o_tlast");
            end
            if (verdict_pending) begin
               check_equal(len_err_strobe, verdict_err, "len_err_strobe");
               check_equal(len_ok_strobe, !verdict_err, "len_ok_strobe");
               if (verdict_err) model_errs++;
               check_equal(err_count, model_errs, "err_count");
            end else begin
               check_equal({len_ok_strobe, len_err_strobe}, 2'b00, "idle verdict strobes");
            end
            verdict_pending = pkt_strobe;
            if (pkt_strobe) check_packet();
         end
      end
   end

   initial begin : run_test
      int   num_pkts;
      int   nwords;
      logic ctrl;
      logic has_time;
      logic len_ok;
      reset           = 1'b1;
      clear           = 1'b0;
      i_tdata         = '0;
      i_tlast         = 1'b0;
      i_tvalid        = 1'b0;
      o_tready        = 1'b0;
      last_ts         = '0;
      model_pkts      = '0;
      model_ctrl      = '0;
      model_errs      = '0;
      verdict_pending = 1'b0;
      verdict_err     = 1'b0;
      repeat (4) @(posedge clk);
      #DRIVE_DELAY;
      reset = 1'b0;

      num_pkts = 40 + pick(41);
      for (int i = 0; i < num_pkts; i++) begin
         // Clear only between packets, once in the middle and at random
         if (i > 0 && (i == num_pkts / 2 || pick(12) == 0)) begin
            wait_idle();
            clear_counters();
         end
         nwords   = 1 + pick(8);
         ctrl     = (pick(2) == 1);
         has_time = (pick(2) == 1);
         len_ok   = (pick(4) != 0);
         send_packet(ctrl, has_time, nwords, len_ok);
      end
      wait_idle();
      check_equal(pkt_count, model_pkts, "final pkt_count");
      check_equal(ctrl_pkt_count, model_ctrl, "final ctrl_pkt_count");
      check_equal(err_count, model_errs, "final err_count");
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
verilog/cvita_debug_pkg.sv
verilog/cvita_pipe_reg.sv
verilog/cvita_packet_monitor.sv
verilog/cvita_length_check.sv
verilog/cvita_debug_top.sv
sim/tb_cvita_debug_top.sv

// File: verilog/cvita_debug_pkg.sv
/*
 * Shared CVITA definitions for the debug tap: word and beat sizes,
 * header field positions and the monitor's packet position type
 */
`default_nettype none

package cvita_debug_pkg;

   // Stream word
   localparam int DATA_W         = 64;
   localparam int BYTES_PER_BEAT = 8;

   // Header fields
   localparam int HDR_CTRL_BIT     = 63;
   localparam int HDR_HAS_TIME_BIT = 61;
   localparam int HDR_LEN_W        = 16;

   // Position of the monitor within a packet
   typedef enum logic [1:0] {
      ST_HEADER = 2'd0,
      ST_TIME   = 2'd1,
      ST_DATA   = 2'd2
   } pkt_state_t;

endpackage

`default_nettype wire

// File: verilog/cvita_debug_top.sv
/*
 * CVITA debug tap: registered pass-through stage with a packet monitor
 * on its output and a header length check behind the monitor
 */
`default_nettype none
`timescale 1ns/1ps

module cvita_debug_top #(
   parameter int COUNT_W = 32
) (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  clear,

   // Stream in
   input  logic [cvita_debug_pkg::DATA_W-1:0]    i_tdata,
   input  logic                                  i_tlast,
   input  logic                                  i_tvalid,
   output logic                                  i_tready,

   // Stream out
   output logic [cvita_debug_pkg::DATA_W-1:0]    o_tdata,
   output logic                                  o_tlast,
   output logic                                  o_tvalid,
   input  logic                                  o_tready,

   // Per-packet capture
   output logic                                  pkt_strobe,
   output logic [cvita_debug_pkg::DATA_W-1:0]    header,
   output logic [cvita_debug_pkg::DATA_W-1:0]    timestamp,
   output logic [cvita_debug_pkg::HDR_LEN_W-1:0] actual_length,
   output logic [cvita_debug_pkg::DATA_W-1:0]    checksum,
   output logic [COUNT_W-1:0]                    pkt_count,
   output logic [COUNT_W-1:0]                    ctrl_pkt_count,

   // Length verdict
   output logic                                  len_ok_strobe,
   output logic                                  len_err_strobe,
   output logic [COUNT_W-1:0]                    err_count
);

   cvita_pipe_reg pipe_reg_i (
      .clk      (clk),
      .reset    (reset),
      .i_tdata  (i_tdata),
      .i_tlast  (i_tlast),
      .i_tvalid (i_tvalid),
      .i_tready (i_tready),
      .o_tdata  (o_tdata),
      .o_tlast  (o_tlast),
      .o_tvalid (o_tvalid),
      .o_tready (o_tready)
   );

   // Monitor sees exactly the beats the downstream accepts
   cvita_packet_monitor #(
      .COUNT_W (COUNT_W)
   ) monitor_i (
      .clk            (clk),
      .reset          (reset),
      .clear          (clear),
      .tdata          (o_tdata),
      .tlast          (o_tlast),
      .tvalid         (o_tvalid),
      .tready         (o_tready),
      .pkt_strobe     (pkt_strobe),
      .header         (header),
      .timestamp      (timestamp),
      .actual_length  (actual_length),
      .checksum       (checksum),
      .pkt_count      (pkt_count),
      .ctrl_pkt_count (ctrl_pkt_count)
   );

   cvita_length_check #(
      .COUNT_W (COUNT_W)
   ) check_i (
      .clk            (clk),
      .reset          (reset),
      .clear          (clear),
      .pkt_strobe     (pkt_strobe),
      .header         (header),
      .actual_length  (actual_length),
      .len_ok_strobe  (len_ok_strobe),
      .len_err_strobe (len_err_strobe),
      .err_count      (err_count)
   );

endmodule

`default_nettype wire

// File: verilog/cvita_length_check.sv
/*
 * Checks the CVITA header length field against the measured packet
 * length and counts mismatches in a saturating counter
 */
`default_nettype none
`timescale 1ns/1ps

module cvita_length_check #(
   parameter int COUNT_W = 32
) (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  clear,

   input  logic                                  pkt_strobe,
   input  logic [cvita_debug_pkg::DATA_W-1:0]    header,
   input  logic [cvita_debug_pkg::HDR_LEN_W-1:0] actual_length,

   output logic                                  len_ok_strobe,
   output logic                                  len_err_strobe,
   output logic [COUNT_W-1:0]                    err_count
);

   localparam int LEN_W = cvita_debug_pkg::HDR_LEN_W;
   localparam int PAD   = cvita_debug_pkg::BYTES_PER_BEAT - 1;

   // One spare bit so a field near 64K does not wrap when rounded up
   logic [LEN_W:0] hdr_len_padded;
   logic [LEN_W:0] hdr_len_rounded;
   logic           len_match;
   logic           err_count_full;

   assign hdr_len_padded  = {1'b0, header[LEN_W-1:0]} + (LEN_W+1)'(PAD);
   assign hdr_len_rounded = hdr_len_padded & ~((LEN_W+1)'(PAD));
   assign len_match       = (hdr_len_rounded == {1'b0, actual_length});
   assign err_count_full  = &err_count;

   always_ff @(posedge clk) begin
      if (reset) begin
         len_ok_strobe  <= 1'b0;
         len_err_strobe <= 1'b0;
      end else begin
         len_ok_strobe  <= pkt_strobe & len_match;
         len_err_strobe <= pkt_strobe & ~len_match;
      end
   end

   // Sticks at all ones
   always_ff @(posedge clk) begin
      if (reset || clear) begin
         err_count <= '0;
      end else if (pkt_strobe && !len_match && !err_count_full) begin
         err_count <= err_count + COUNT_W'(1);
      end
   end

   a_verdict_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(len_ok_strobe && len_err_strobe))
      else $error("length ok and error strobes both high");

endmodule

`default_nettype wire

// File: verilog/cvita_packet_monitor.sv
/*
 * Passive CVITA packet monitor: captures header, timestamp, length and
 * payload checksum per packet and keeps packet and control packet counts
 */
`default_nettype none
`timescale 1ns/1ps

module cvita_packet_monitor #(
   parameter int COUNT_W = 32
) (
   input  logic                                  clk,
   input  logic                                  reset,
   input  logic                                  clear,

   // Tap on a transferred stream
   input  logic [cvita_debug_pkg::DATA_W-1:0]    tdata,
   input  logic                                  tlast,
   input  logic                                  tvalid,
   input  logic                                  tready,

   // Per-packet results
   output logic                                  pkt_strobe,
   output logic [cvita_debug_pkg::DATA_W-1:0]    header,
   output logic [cvita_debug_pkg::DATA_W-1:0]    timestamp,
   output logic [cvita_debug_pkg::HDR_LEN_W-1:0] actual_length,
   output logic [cvita_debug_pkg::DATA_W-1:0]    checksum,

   // Statistics
   output logic [COUNT_W-1:0]                    pkt_count,
   output logic [COUNT_W-1:0]                    ctrl_pkt_count
);

   localparam int LEN_W = cvita_debug_pkg::HDR_LEN_W;

   cvita_debug_pkg::pkt_state_t pkt_state;

   logic xfer;
   logic is_ctrl;

   assign xfer = tvalid & tready;

   // Control bit comes from the live beat when the packet is a lone header
   assign is_ctrl = (pkt_state == cvita_debug_pkg::ST_HEADER) ?
                    tdata[cvita_debug_pkg::HDR_CTRL_BIT] :
                    header[cvita_debug_pkg::HDR_CTRL_BIT];

   always_ff @(posedge clk) begin
      if (reset) begin
         pkt_state <= cvita_debug_pkg::ST_HEADER;
      end else if (xfer) begin
         case (pkt_state)
            cvita_debug_pkg::ST_HEADER: begin
               if (!tlast) begin
                  pkt_state <= tdata[cvita_debug_pkg::HDR_HAS_TIME_BIT] ?
                               cvita_debug_pkg::ST_TIME : cvita_debug_pkg::ST_DATA;
               end
            end
            cvita_debug_pkg::ST_TIME,
            cvita_debug_pkg::ST_DATA: begin
               pkt_state <= tlast ? cvita_debug_pkg::ST_HEADER : cvita_debug_pkg::ST_DATA;
            end
            default: pkt_state <= cvita_debug_pkg::ST_HEADER;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pkt_strobe <= 1'b0;
      end else begin
         pkt_strobe <= xfer & tlast;
      end
   end

   // Header and timestamp hold until the next packet overwrites them
   always_ff @(posedge clk) begin
      if (reset) begin
         header    <= '0;
         timestamp <= '0;
      end else if (xfer) begin
         if (pkt_state == cvita_debug_pkg::ST_HEADER) begin
            header <= tdata;
         end
         if (pkt_state == cvita_debug_pkg::ST_TIME) begin
            timestamp <= tdata;
         end
      end
   end

   // Length includes the header beat, checksum covers data words only
   always_ff @(posedge clk) begin
      if (xfer) begin
         if (pkt_state == cvita_debug_pkg::ST_HEADER) begin
            actual_length <= LEN_W'(cvita_debug_pkg::BYTES_PER_BEAT);
            checksum      <= '0;
         end else begin
            actual_length <= actual_length + LEN_W'(cvita_debug_pkg::BYTES_PER_BEAT);
            if (pkt_state == cvita_debug_pkg::ST_DATA) begin
               checksum <= checksum ^ tdata;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset || clear) begin
         pkt_count      <= '0;
         ctrl_pkt_count <= '0;
      end else if (xfer && tlast) begin
         pkt_count <= pkt_count + COUNT_W'(1);
         if (is_ctrl) begin
            ctrl_pkt_count <= ctrl_pkt_count + COUNT_W'(1);
         end
      end
   end

   a_state_legal: assert property (@(posedge clk) disable iff (reset)
      pkt_state inside {cvita_debug_pkg::ST_HEADER, cvita_debug_pkg::ST_TIME,
                        cvita_debug_pkg::ST_DATA})
      else $error("packet monitor state left the legal set");

endmodule

`default_nettype wire

// File: verilog/cvita_pipe_reg.sv
/*
 * Single registered stage for a 64-bit valid/ready/last stream,
 * one beat per cycle when the output is not stalled
 */
`default_nettype none
`timescale 1ns/1ps

module cvita_pipe_reg (
   input  logic                                clk,
   input  logic                                reset,

   input  logic [cvita_debug_pkg::DATA_W-1:0]  i_tdata,
   input  logic                                i_tlast,
   input  logic                                i_tvalid,
   output logic                                i_tready,

   output logic [cvita_debug_pkg::DATA_W-1:0]  o_tdata,
   output logic                                o_tlast,
   output logic                                o_tvalid,
   input  logic                                o_tready
);

   // Accept while the register is empty or being drained this cycle
   assign i_tready = ~o_tvalid | o_tready;

   always_ff @(posedge clk) begin
      if (reset) begin
         o_tvalid <= 1'b0;
      end else if (i_tready) begin
         o_tvalid <= i_tvalid;
      end
   end

   // Word and last only move on an accepted beat
   always_ff @(posedge clk) begin
      if (i_tready && i_tvalid) begin
         o_tdata <= i_tdata;
         o_tlast <= i_tlast;
      end
   end

   // Held beat must not change under back-pressure
   property p_hold_under_stall;
      @(posedge clk) disable iff (reset)
         (o_tvalid && !o_tready) |=> (o_tvalid && $stable(o_tdata) && $stable(o_tlast));
   endproperty

   a_hold_under_stall: assert property (p_hold_under_stall)
      else $error("output beat changed while stalled");

endmodule

`default_nettype wire
